//--- sim/blas_testdata.txt
// Columns, one hex word per record: test _ kind _ mask _ addr _ op _ data
// Kinds: 0 write, 1 read and compare with data, 2 exec (addr = length-1, data = a),
// 3 LFSR fill, 4 read all vs model, 5 wait for commits, 6 wait_o seen, 7 end of test,
// 8 fill data + word*1111
1_8_1_0_0_1234
1_8_2_0_0_ABCD
1_1_1_7_0_89AB
1_1_2_0_0_ABCD
1_4_1_0_0_0000
1_4_2_0_0_0000
1_7_0_0_0_0000
2_8_1_0_0_0001
2_8_2_0_0_0100
2_2_1_2_0_0003
2_2_2_2_2_0000
2_5_0_0_0_0000
2_1_1_4_0_0003
2_1_1_5_0_3336
2_1_1_6_0_6669
2_1_1_7_0_7778
2_1_2_4_0_4644
2_1_2_5_0_6866
2_1_2_6_0_8A88
2_1_2_7_0_7877
2_7_0_0_0_0000
3_8_1_0_0_F000
3_8_2_0_0_FFFF
3_2_3_3_1_0010
3_5_0_0_0_0000
3_1_1_4_0_3444
3_1_1_5_0_5665
3_1_1_6_0_7886
3_1_1_7_0_9AA7
3_1_2_4_0_4433
3_1_2_5_0_6654
3_1_2_6_0_8875
3_1_2_7_0_AA96
3_7_0_0_0_0000
4_3_1_0_0_0000
4_3_2_0_0_0000
4_2_1_3_1_0007
4_2_2_0_2_0000
4_5_0_0_0_0000
4_4_1_0_0_0000
4_4_2_0_0_0000
4_7_0_0_0_0000
5_8_1_0_0_0042
5_2_1_3_1_0003
5_2_1_1_1_0005
5_2_1_0_2_0000
5_2_1_3_0_0002
5_2_1_2_1_FFFF
5_6_0_0_0_0000
5_5_0_0_0_0000
5_4_1_0_0_0000
5_7_0_0_0_0000

//--- blas_engine.f
common/blas_pkg.sv
mpu/mpu.sv
mpu/commit_agg.sv
tpu/tpu.sv
tpu/dmem.sv
src/router.sv
src/blas_engine.sv
sim/tb_clk.sv
sim/tb_blas_engine.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert -j 0
TOP       := tb_blas_engine
FILELIST  := blas_engine.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TB FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_blas_engine.sv
// Testbench for the vector engine. Replays the records of
// sim/blas_testdata.txt, keeps a model of both memories and checks read
// data, commit order and the return to idle after each burst.

`timescale 1ns/10ps

module tb_blas_engine
	import blas_pkg::*;
;

	localparam int TMO = 400;					// Cycles per wait
	localparam int NREC = 128;

	logic						clock;
	logic						rst_n;
	logic						req;
	cmd_e						cmd;
	logic	[NUM_TPUS-1:0]		mask;
	logic	[ADDR_W-1:0]		addr;
	op_e						op;
	logic	[DATA_W-1:0]		data_in;
	logic						wait_o;
	logic	[DATA_W-1:0]		rd_data;
	logic						rd_valid;
	logic						commit;
	logic	[ISSUE_W-1:0]		commit_no;
	logic						busy;

	logic	[35:0]				recs		[NREC];	// test, kind, mask, addr, op, data
	logic	[DATA_W-1:0]		model		[NUM_TPUS][MEM_DEPTH];
	logic	[31:0]				lfsr;
	logic	[ISSUE_W-1:0]		next_no;
	logic	[ISSUE_W-1:0]		exp_q[$];
	logic	[ISSUE_W-1:0]		got_q[$];
	int							cur_test;
	int							tests;
	int							checks;
	int							errors;
	int							t_checks;
	int							t_errs;
	bit							hung;
	bit							saw_wait;

	tb_clk clk_gen_i (.clock(clock));

	blas_engine blas_engine_i (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.req(		req			),
		.cmd(		cmd			),
		.mask(		mask		),
		.addr(		addr		),
		.op(		op			),
		.data_in(	data_in		),
		.wait_o(	wait_o		),
		.rd_data(	rd_data		),
		.rd_valid(	rd_valid	),
		.commit(	commit		),
		.commit_no(	commit_no	),
		.busy(		busy		)
	);

	// Commits are sampled mid cycle
	always @(negedge clock) begin
		if (rst_n === 1'b1 && commit === 1'b1) begin
			got_q.push_back(commit_no);
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	function automatic int unit_of(input logic [NUM_TPUS-1:0] m);
		unit_of = 0;
		for (int k = 0; k < NUM_TPUS; k++) begin
			if (m[k]) begin
				unit_of = k;
			end
		end
	endfunction

	task automatic rand_word(output logic [DATA_W-1:0] w);
		for (int b = 0; b < DATA_W; b++) begin
			lfsr = lfsr_next(lfsr);					// One step per bit
			w[b] = lfsr[0];
		end
	endtask

	//////////////////////////////
	// Host command tasks
	//////////////////////////////
	task automatic send_cmd(input cmd_e c, input logic [NUM_TPUS-1:0] m,
			input logic [ADDR_W-1:0] a, input op_e o, input logic [DATA_W-1:0] d);
		int n;
		n = 0;
		while (wait_o !== 1'b0 && !hung) begin
			if (c == CMD_EXEC) begin
				saw_wait = 1'b1;
			end
			if (n >= TMO) begin
				$display("test %0d: timed out waiting for wait_o to fall", cur_test);
				hung = 1'b1;
			end else begin
				@(negedge clock);
				n++;
			end
		end
		if (!hung) begin
			req = 1'b1;
			cmd = c;
			mask = m;
			addr = a;
			op = o;
			data_in = d;
			@(negedge clock);
			req = 1'b0;
		end
	endtask

	task automatic write_word(input int u, input logic [ADDR_W-1:0] a,
			input logic [DATA_W-1:0] d);
		send_cmd(CMD_WRITE, NUM_TPUS'(1) << u, a, OP_SCALE, d);
		model[u][a] = d;
	endtask

	task automatic read_word(input logic [NUM_TPUS-1:0] m, input logic [ADDR_W-1:0] a,
			output logic [DATA_W-1:0] d);
		int n;
		d = '0;
		send_cmd(CMD_READ, m, a, OP_SCALE, '0);
		n = 0;
		while (rd_valid !== 1'b1 && !hung) begin
			if (n >= TMO) begin
				$display("test %0d: timed out waiting for rd_valid", cur_test);
				hung = 1'b1;
			end else begin
				@(negedge clock);
				n++;
			end
		end
		d = rd_data;
	endtask

	// Expected memory after an instruction, element by element
	task automatic exec_cmd(input logic [NUM_TPUS-1:0] m, input logic [ADDR_W-1:0] lm1,
			input op_e o, input logic [DATA_W-1:0] s);
		logic	[DATA_W-1:0]	x;
		logic	[DATA_W-1:0]	y;
		send_cmd(CMD_EXEC, m, lm1, o, s);
		for (int u = 0; u < NUM_TPUS; u++) begin
			for (int i = 0; i <= int'(lm1) && m[u]; i++) begin
				x = model[u][i];
				y = model[u][Y_BASE + i];
				case (o)
					OP_SCALE:	y = s * x;
					OP_AXPY:	y = s * x + y;
					default:	y = x + y;
				endcase
				model[u][Y_BASE + i] = y;
			end
		end
		exp_q.push_back(next_no);
		next_no = next_no + ISSUE_W'(1);
	endtask

	task automatic read_all(input logic [NUM_TPUS-1:0] m);
		logic	[DATA_W-1:0]	got;
		int						u;
		u = unit_of(m);
		for (int a = 0; a < MEM_DEPTH && !hung; a++) begin
			read_word(m, ADDR_W'(a), got);
			t_checks++;
			if (!hung && got !== model[u][a]) begin
				t_errs++;
				$display("** Error test %0d: rd_data unit %0d word %0d got %h expected %h",
					cur_test, u, a, got, model[u][a]);
			end
		end
	endtask

	task automatic sync_commits();
		logic	[ISSUE_W-1:0]	e;
		logic	[ISSUE_W-1:0]	g;
		int						n;
		n = 0;
		while (got_q.size() < exp_q.size() && !hung) begin
			if (n >= TMO) begin
				$display("test %0d: timed out waiting for commit", cur_test);
				hung = 1'b1;
			end else begin
				@(negedge clock);
				n++;
			end
		end
		n = 0;
		while (busy !== 1'b0 && !hung) begin
			if (n >= TMO) begin
				$display("test %0d: busy did not fall after the last commit", cur_test);
				hung = 1'b1;
			end else begin
				@(negedge clock);
				n++;
			end
		end
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			t_checks++;
			if (g !== e) begin
				t_errs++;
				$display("** Error test %0d: commit_no got %h expected %h", cur_test, g, e);
			end
		end
		if (got_q.size() != 0) begin
			t_errs++;
			$display("test %0d: %0d commits arrived with nothing issued", cur_test,
				got_q.size());
		end
		exp_q.delete();
		got_q.delete();
	endtask

	//////////////////////////////
	// Record replay
	//////////////////////////////
	initial begin
		int						i;
		logic	[35:0]			r;
		logic	[3:0]			kind;
		logic	[NUM_TPUS-1:0]	m;
		logic	[ADDR_W-1:0]	a;
		logic	[DATA_W-1:0]	d;
		logic	[DATA_W-1:0]	w;
		rst_n = 1'b0;
		req = 1'b0;
		cmd = CMD_WRITE;
		mask = '0;
		addr = '0;
		op = OP_SCALE;
		data_in = '0;
		lfsr = 32'h1e6c;
		next_no = '0;
		{cur_test, tests, checks, errors, t_checks, t_errs} = '0;
		hung = 1'b0;
		saw_wait = 1'b0;
		for (i = 0; i < NREC; i++) begin
			recs[i] = '1;							// Kind F ends the list
		end
		$readmemh("sim/blas_testdata.txt", recs);

		repeat (8) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		checks++;
		if ({wait_o, rd_valid, commit, busy} !== 4'b0000) begin
			errors++;
			$display("** Error reset: {wait_o,rd_valid,commit,busy} got %h expected 0",
				{wait_o, rd_valid, commit, busy});
		end

		i = 0;
		while (!hung && i < NREC && recs[i][31:28] != 4'hF) begin
			r = recs[i];
			cur_test = int'(r[35:32]);
			kind = r[31:28];
			m = NUM_TPUS'(r[27:24]);
			a = ADDR_W'(r[23:20]);
			d = r[15:0];
			case (kind)
				4'h0: write_word(unit_of(m), a, d);
				4'h1: begin
					read_word(m, a, w);
					t_checks++;
					if (!hung && w !== d) begin
						t_errs++;
						$display("** Error test %0d: rd_data unit %0d word %0d got %h expected %h",
							cur_test, unit_of(m), a, w, d);
					end
				end
				4'h2: exec_cmd(m, a, op_e'(r[17:16]), d);
				4'h3: begin
					for (int k = 0; k < MEM_DEPTH; k++) begin
						rand_word(w);
						write_word(unit_of(m), ADDR_W'(k), w);
					end
				end
				4'h4: read_all(m);
				4'h5: sync_commits();
				4'h6: begin
					t_checks++;
					if (!saw_wait) begin
						t_errs++;
						$display("test %0d: wait_o never rose during the exec burst", cur_test);
					end
				end
				4'h7: begin
					$display("test %0d: %0d checks, %0d errors", cur_test, t_checks, t_errs);
					tests++;
					checks += t_checks;
					errors += t_errs;
					t_checks = 0;
					t_errs = 0;
					saw_wait = 1'b0;
				end
				4'h8: begin
					for (int k = 0; k < MEM_DEPTH; k++) begin
						write_word(unit_of(m), ADDR_W'(k), d + DATA_W'(k) * 16'h1111);
					end
				end
				default: begin
					t_errs++;
					$display("record %0d has an unknown kind %h", i, kind);
				end
			endcase
			i++;
		end

		checks += t_checks;
		errors += t_errs + (hung ? 1 : 0);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && tests > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- sim/tb_clk.sv
// Free running clock for the testbench, 20 ns period.
// Instantiated once by the testbench top.

`timescale 1ns/10ps

module tb_clk (
	output	logic	clock
);

	localparam time HALF = 10ns;

	initial begin
		clock = 1'b0;
		forever begin
			#HALF clock = ~clock;
		end
	end

endmodule

//--- src/blas_engine.sv
// Top level of the vector engine. Control unit and commit buffer at
// the head of a one-column chain of routers, each with its thread unit
// and local memory. Host ports are plain strobes.

`timescale 1ns/10ps

module blas_engine
	import blas_pkg::*;
(
	input	logic						clock,
	input	logic						rst_n,
	input	logic						req,
	input	cmd_e						cmd,
	input	logic	[NUM_TPUS-1:0]		mask,
	input	logic	[ADDR_W-1:0]		addr,
	input	op_e						op,
	input	logic	[DATA_W-1:0]		data_in,
	output	logic						wait_o,
	output	logic	[DATA_W-1:0]		rd_data,
	output	logic						rd_valid,
	output	logic						commit,
	output	logic	[ISSUE_W-1:0]		commit_no,
	output	logic						busy
);

	//////////////////////////////
	// Chain and issue wires
	//////////////////////////////
	logic						fwd_req		[NUM_TPUS+1];
	logic						fwd_we		[NUM_TPUS+1];
	logic	[DST_W-1:0]			fwd_dst		[NUM_TPUS+1];
	logic	[ADDR_W-1:0]		fwd_addr	[NUM_TPUS+1];
	logic	[DATA_W-1:0]		fwd_data	[NUM_TPUS+1];
	logic						fwd_hit		[NUM_TPUS];
	logic						bwd_vld		[NUM_TPUS+1];
	logic	[DATA_W-1:0]		bwd_data	[NUM_TPUS+1];

	logic						issue;
	logic	[ISSUE_W-1:0]		issue_no;
	op_e						exe_op;
	logic	[ADDR_W-1:0]		exe_len;
	logic	[DATA_W-1:0]		exe_scalar;
	logic	[NUM_TPUS-1:0]		en_exe;
	logic	[NUM_TPUS-1:0]		tpu_busy;
	logic	[NUM_TPUS-1:0]		term;
	logic	[NUM_TPUS-1:0][ISSUE_W-1:0]	term_no;
	logic						agg_full;
	logic						agg_empty;

	// Per unit memory ports
	logic	[ADDR_W-1:0]		raddr_x		[NUM_TPUS];
	logic	[ADDR_W-1:0]		raddr_y		[NUM_TPUS];
	logic	[DATA_W-1:0]		rdata_x		[NUM_TPUS];
	logic	[DATA_W-1:0]		rdata_y		[NUM_TPUS];
	logic						mem_we		[NUM_TPUS];
	logic	[ADDR_W-1:0]		mem_waddr	[NUM_TPUS];
	logic	[DATA_W-1:0]		mem_wdata	[NUM_TPUS];
	logic						rt_we		[NUM_TPUS];
	logic						rt_re		[NUM_TPUS];
	logic	[ADDR_W-1:0]		rt_addr		[NUM_TPUS];
	logic	[DATA_W-1:0]		rt_wdata	[NUM_TPUS];
	logic	[DATA_W-1:0]		rt_rdata	[NUM_TPUS];
	logic						rt_rvld		[NUM_TPUS];

	assign busy = (|tpu_busy) | ~agg_empty;
	assign bwd_vld[NUM_TPUS] = 1'b0;			// End of the chain
	assign bwd_data[NUM_TPUS] = '0;

	mpu mpu_i (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.req(			req				),
		.cmd(			cmd				),
		.mask(			mask			),
		.addr(			addr			),
		.op(			op				),
		.data_in(		data_in			),
		.wait_o(		wait_o			),
		.rd_data(		rd_data			),
		.rd_valid(		rd_valid		),
		.fwd_req(		fwd_req[0]		),
		.fwd_we(		fwd_we[0]		),
		.fwd_dst(		fwd_dst[0]		),
		.fwd_addr(		fwd_addr[0]		),
		.fwd_data(		fwd_data[0]		),
		.bwd_vld(		bwd_vld[0]		),
		.bwd_data(		bwd_data[0]		),
		.issue(			issue			),
		.issue_no(		issue_no		),
		.exe_op(		exe_op			),
		.exe_len(		exe_len			),
		.exe_scalar(	exe_scalar		),
		.en_exe(		en_exe			),
		.tpu_busy(		tpu_busy		),
		.agg_full(		agg_full		)
	);

	commit_agg commit_agg_i (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.issue(			issue			),
		.issue_no(		issue_no		),
		.en_exe(		en_exe			),
		.term(			term			),
		.term_no(		term_no			),
		.commit(		commit			),
		.commit_no(		commit_no		),
		.full(			agg_full		),
		.empty(			agg_empty		)
	);

	//////////////////////////////
	// One hop per thread unit
	//////////////////////////////
	for (genvar k = 0; k < NUM_TPUS; k++) begin : g_unit
		assign fwd_hit[k] = (fwd_dst[k] == DST_W'(k));

		router router_i (
			.clock(		clock			),
			.rst_n(		rst_n			),
			.fwd_req(	fwd_req[k]		),
			.fwd_we(	fwd_we[k]		),
			.fwd_hit(	fwd_hit[k]		),
			.fwd_dst(	fwd_dst[k]		),
			.fwd_addr(	fwd_addr[k]		),
			.fwd_data(	fwd_data[k]		),
			.nxt_req(	fwd_req[k+1]	),
			.nxt_we(	fwd_we[k+1]		),
			.nxt_dst(	fwd_dst[k+1]	),
			.nxt_addr(	fwd_addr[k+1]	),
			.nxt_data(	fwd_data[k+1]	),
			.ret_vld(	bwd_vld[k+1]	),
			.ret_data(	bwd_data[k+1]	),
			.bwd_vld(	bwd_vld[k]		),
			.bwd_data(	bwd_data[k]		),
			.rt_we(		rt_we[k]		),
			.rt_re(		rt_re[k]		),
			.rt_addr(	rt_addr[k]		),
			.rt_wdata(	rt_wdata[k]		),
			.rt_rdata(	rt_rdata[k]		),
			.rt_rvld(	rt_rvld[k]		)
		);

		tpu tpu_i (
			.clock(			clock			),
			.rst_n(			rst_n			),
			.en_exe(		en_exe[k]		),
			.issue(			issue			),
			.issue_no(		issue_no		),
			.exe_op(		exe_op			),
			.exe_len(		exe_len			),
			.exe_scalar(	exe_scalar		),
			.busy(			tpu_busy[k]		),
			.term(			term[k]			),
			.term_no(		term_no[k]		),
			.mem_raddr_x(	raddr_x[k]		),
			.mem_raddr_y(	raddr_y[k]		),
			.mem_rdata_x(	rdata_x[k]		),
			.mem_rdata_y(	rdata_y[k]		),
			.mem_we(		mem_we[k]		),
			.mem_waddr(		mem_waddr[k]	),
			.mem_wdata(		mem_wdata[k]	)
		);

		dmem dmem_i (
			.clock(		clock			),
			.rst_n(		rst_n			),
			.raddr_x(	raddr_x[k]		),
			.rdata_x(	rdata_x[k]		),
			.raddr_y(	raddr_y[k]		),
			.rdata_y(	rdata_y[k]		),
			.we(		mem_we[k]		),
			.waddr(		mem_waddr[k]	),
			.wdata(		mem_wdata[k]	),
			.rt_we(		rt_we[k]		),
			.rt_re(		rt_re[k]		),
			.rt_addr(	rt_addr[k]		),
			.rt_wdata(	rt_wdata[k]		),
			.rt_rdata(	rt_rdata[k]		),
			.rt_rvld(	rt_rvld[k]		)
		);
	end

endmodule

//--- src/router.sv
// One hop of the router chain. Registers the forward word, hands it to
// the local memory when hit is set, otherwise passes it on. Read data
// returns toward the control unit one register per hop.

`timescale 1ns/10ps

module router
	import blas_pkg::*;
(
	input	logic						clock,
	input	logic						rst_n,
	input	logic						fwd_req,
	input	logic						fwd_we,
	input	logic						fwd_hit,		// Destination is this hop
	input	logic	[DST_W-1:0]			fwd_dst,
	input	logic	[ADDR_W-1:0]		fwd_addr,
	input	logic	[DATA_W-1:0]		fwd_data,
	output	logic						nxt_req,
	output	logic						nxt_we,
	output	logic	[DST_W-1:0]			nxt_dst,
	output	logic	[ADDR_W-1:0]		nxt_addr,
	output	logic	[DATA_W-1:0]		nxt_data,
	input	logic						ret_vld,		// From the next hop
	input	logic	[DATA_W-1:0]		ret_data,
	output	logic						bwd_vld,
	output	logic	[DATA_W-1:0]		bwd_data,
	output	logic						rt_we,
	output	logic						rt_re,
	output	logic	[ADDR_W-1:0]		rt_addr,
	output	logic	[DATA_W-1:0]		rt_wdata,
	input	logic	[DATA_W-1:0]		rt_rdata,
	input	logic						rt_rvld
);

	logic		q_req;
	logic		q_hit;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			q_req <= 1'b0;
			q_hit <= 1'b0;
			bwd_vld <= 1'b0;
		end else begin
			q_req <= fwd_req;
			q_hit <= fwd_hit;
			bwd_vld <= rt_rvld | ret_vld;
		end
	end

	always_ff @(posedge clock) begin
		nxt_we <= fwd_we;
		nxt_dst <= fwd_dst;
		nxt_addr <= fwd_addr;
		nxt_data <= fwd_data;
		bwd_data <= rt_rvld ? rt_rdata : ret_data;	// Never both valid
	end

	assign nxt_req = q_req & ~q_hit;
	assign rt_we = q_req & q_hit & nxt_we;
	assign rt_re = q_req & q_hit & ~nxt_we;
	assign rt_addr = nxt_addr;
	assign rt_wdata = nxt_data;

endmodule

//--- tpu/dmem.sv
// Local data memory of one thread unit. Two combinational read ports
// for the unit, one write port shared by the unit and the router,
// and a registered router read that answers one cycle later.

`timescale 1ns/10ps

module dmem
	import blas_pkg::*;
(
	input	logic						clock,
	input	logic						rst_n,
	input	logic	[ADDR_W-1:0]		raddr_x,
	output	logic	[DATA_W-1:0]		rdata_x,
	input	logic	[ADDR_W-1:0]		raddr_y,
	output	logic	[DATA_W-1:0]		rdata_y,
	input	logic						we,
	input	logic	[ADDR_W-1:0]		waddr,
	input	logic	[DATA_W-1:0]		wdata,
	input	logic						rt_we,
	input	logic						rt_re,
	input	logic	[ADDR_W-1:0]		rt_addr,
	input	logic	[DATA_W-1:0]		rt_wdata,
	output	logic	[DATA_W-1:0]		rt_rdata,
	output	logic						rt_rvld
);

	logic	[DATA_W-1:0]		mem	[MEM_DEPTH];

	assign rdata_x = mem[raddr_x];
	assign rdata_y = mem[raddr_y];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;			// Thread unit first
		end else if (rt_we) begin
			mem[rt_addr] <= rt_wdata;
		end
		rt_rdata <= mem[rt_addr];
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rt_rvld <= 1'b0;
		end else begin
			rt_rvld <= rt_re;
		end
	end

	// Host traffic only reaches idle units
	assert property (@(posedge clock) disable iff (!rst_n) rt_we |-> !we)
		else $error("dmem: router write during thread write");

endmodule

//--- tpu/tpu.sv
// Thread unit. Runs one vector instruction over its local memory, one
// element per cycle, x at words 0..3 and y at Y_BASE onward.
// Pulses term with the latched issue number when done.

`timescale 1ns/10ps

module tpu
	import blas_pkg::*;
(
	input	logic						clock,
	input	logic						rst_n,
	input	logic						en_exe,
	input	logic						issue,
	input	logic	[ISSUE_W-1:0]		issue_no,
	input	op_e						exe_op,
	input	logic	[ADDR_W-1:0]		exe_len,
	input	logic	[DATA_W-1:0]		exe_scalar,
	output	logic						busy,
	output	logic						term,
	output	logic	[ISSUE_W-1:0]		term_no,
	output	logic	[ADDR_W-1:0]		mem_raddr_x,
	output	logic	[ADDR_W-1:0]		mem_raddr_y,
	input	logic	[DATA_W-1:0]		mem_rdata_x,
	input	logic	[DATA_W-1:0]		mem_rdata_y,
	output	logic						mem_we,
	output	logic	[ADDR_W-1:0]		mem_waddr,
	output	logic	[DATA_W-1:0]		mem_wdata
);

	tpu_st_e					state;
	logic	[ADDR_W-1:0]		idx;		// Current element
	logic	[ADDR_W-1:0]		last;
	op_e						op_q;
	logic	[DATA_W-1:0]		scalar;
	logic	[DATA_W-1:0]		prod;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (issue && en_exe) begin
						state <= ST_RUN;
						idx <= '0;
					end
				end
				ST_RUN: begin
					if (idx == last) begin
						state <= ST_TERM;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				default: state <= ST_IDLE;		// One cycle of term
			endcase
		end
	end

	// Instruction fields, taken on issue
	always_ff @(posedge clock) begin
		if (state == ST_IDLE && issue && en_exe) begin
			last <= exe_len;
			op_q <= exe_op;
			scalar <= exe_scalar;
			term_no <= issue_no;
		end
	end

	assign busy = (state != ST_IDLE);
	assign term = (state == ST_TERM);

	//////////////////////////////
	// Element datapath
	//////////////////////////////
	assign mem_raddr_x = idx;
	assign mem_raddr_y = Y_BASE + idx;
	assign mem_waddr = mem_raddr_y;		// Result overwrites y
	assign mem_we = (state == ST_RUN);
	assign prod = scalar * mem_rdata_x;	// Wraps at 16 bits

	always_comb begin
		case (op_q)
			OP_SCALE:	mem_wdata = prod;
			OP_AXPY:	mem_wdata = prod + mem_rdata_y;
			default:	mem_wdata = mem_rdata_x + mem_rdata_y;
		endcase
	end

endmodule

//--- mpu/commit_agg.sv
// In-order commit buffer. One entry per issued instruction, indexed by
// its issue number, holding the units that have not yet terminated.
// Only the head entry retires, so commits leave in issue order.

`timescale 1ns/10ps

module commit_agg
	import blas_pkg::*;
(
	input	logic									clock,
	input	logic									rst_n,
	input	logic									issue,
	input	logic	[ISSUE_W-1:0]					issue_no,
	input	logic	[NUM_TPUS-1:0]					en_exe,
	input	logic	[NUM_TPUS-1:0]					term,
	input	logic	[NUM_TPUS-1:0][ISSUE_W-1:0]		term_no,
	output	logic									commit,
	output	logic	[ISSUE_W-1:0]					commit_no,
	output	logic									full,
	output	logic									empty
);

	logic	[AGG_DEPTH-1:0]					vld;
	logic	[AGG_DEPTH-1:0][NUM_TPUS-1:0]	pmask;		// Units still running
	logic	[ISSUE_W-1:0]					head;
	logic									pop;

	assign pop = vld[head] && (pmask[head] == '0);
	assign commit = pop;
	assign commit_no = head;
	assign full = &vld;
	assign empty = ~|vld;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			vld <= '0;
			pmask <= '0;
			head <= '0;
		end else begin
			for (int u = 0; u < NUM_TPUS; u++) begin
				if (term[u]) begin
					pmask[term_no[u]][u] <= 1'b0;
				end
			end
			// New entry never sees a term in its push cycle
			if (issue) begin
				vld[issue_no] <= 1'b1;
				pmask[issue_no] <= en_exe;
			end
			if (pop) begin
				vld[head] <= 1'b0;
				head <= head + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	assert property (@(posedge clock) disable iff (!rst_n) issue |-> !full)
		else $error("commit_agg: push while full");

	for (genvar u = 0; u < NUM_TPUS; u++) begin : g_chk
		assert property (@(posedge clock) disable iff (!rst_n)
			term[u] |-> (vld[term_no[u]] && pmask[term_no[u]][u]))
			else $error("commit_agg: term %0d for unknown issue %0d", u, term_no[u]);
	end

endmodule

//--- mpu/mpu.sv
// Control unit. Decodes host commands, holds one command until its
// target units are idle, then injects a router word or issues a vector
// instruction with a wrapping issue number.

`timescale 1ns/10ps

module mpu
	import blas_pkg::*;
(
	input	logic						clock,
	input	logic						rst_n,
	input	logic						req,
	input	cmd_e						cmd,
	input	logic	[NUM_TPUS-1:0]		mask,
	input	logic	[ADDR_W-1:0]		addr,
	input	op_e						op,
	input	logic	[DATA_W-1:0]		data_in,
	output	logic						wait_o,
	output	logic	[DATA_W-1:0]		rd_data,
	output	logic						rd_valid,
	output	logic						fwd_req,
	output	logic						fwd_we,
	output	logic	[DST_W-1:0]			fwd_dst,
	output	logic	[ADDR_W-1:0]		fwd_addr,
	output	logic	[DATA_W-1:0]		fwd_data,
	input	logic						bwd_vld,
	input	logic	[DATA_W-1:0]		bwd_data,
	output	logic						issue,
	output	logic	[ISSUE_W-1:0]		issue_no,
	output	op_e						exe_op,
	output	logic	[ADDR_W-1:0]		exe_len,
	output	logic	[DATA_W-1:0]		exe_scalar,
	output	logic	[NUM_TPUS-1:0]		en_exe,
	input	logic	[NUM_TPUS-1:0]		tpu_busy,
	input	logic						agg_full
);

	logic						pend_vld;
	cmd_e						pend_cmd;
	logic	[NUM_TPUS-1:0]		pend_mask;
	logic	[ADDR_W-1:0]		pend_addr;
	op_e						pend_op;
	logic	[DATA_W-1:0]		pend_data;
	logic						rd_pend;			// One read in the chain
	logic	[FLY_W-1:0]			fly_cnt;			// Write still travelling
	logic						tgt_idle;
	logic						go;
	logic						acc;

	//////////////////////////////
	// Dispatch decision
	//////////////////////////////
	always_comb begin
		tgt_idle = ~|(pend_mask & tpu_busy);
		case (pend_cmd)
			CMD_EXEC:	go = pend_vld && tgt_idle && !agg_full && (fly_cnt == '0);
			CMD_READ:	go = pend_vld && tgt_idle && !rd_pend;
			default:	go = pend_vld && tgt_idle;
		endcase
	end

	assign wait_o = rd_pend | (pend_vld & ~go) | agg_full;
	assign acc = req & ~wait_o;

	// Mask is one-hot for WRITE and READ
	always_comb begin
		fwd_dst = '0;
		for (int k = 0; k < NUM_TPUS; k++) begin
			if (pend_mask[k]) begin
				fwd_dst = DST_W'(k);
			end
		end
	end

	assign fwd_req = go && (pend_cmd != CMD_EXEC);
	assign fwd_we = (pend_cmd == CMD_WRITE);
	assign fwd_addr = pend_addr;
	assign fwd_data = pend_data;

	assign issue = go && (pend_cmd == CMD_EXEC);
	assign exe_op = pend_op;
	assign exe_len = pend_addr;				// Length minus one
	assign exe_scalar = pend_data;
	assign en_exe = pend_mask;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pend_vld <= 1'b0;
			rd_pend <= 1'b0;
			fly_cnt <= '0;
			issue_no <= '0;
			rd_valid <= 1'b0;
		end else begin
			if (acc) begin
				pend_vld <= 1'b1;
			end else if (go) begin
				pend_vld <= 1'b0;
			end
			if (fwd_req && !fwd_we) begin
				rd_pend <= 1'b1;
			end else if (bwd_vld) begin
				rd_pend <= 1'b0;
			end
			if (fwd_req && fwd_we) begin
				fly_cnt <= FLY_W'(NUM_TPUS);
			end else if (fly_cnt != '0) begin
				fly_cnt <= fly_cnt - 1'b1;
			end
			if (issue) begin
				issue_no <= issue_no + 1'b1;
			end
			rd_valid <= bwd_vld;
		end
	end

	always_ff @(posedge clock) begin
		if (acc) begin
			pend_cmd <= cmd;
			pend_mask <= mask;
			pend_addr <= addr;
			pend_op <= op;
			pend_data <= data_in;
		end
		if (bwd_vld) begin
			rd_data <= bwd_data;
		end
	end

	// Host honours back-pressure
	assert property (@(posedge clock) disable iff (!rst_n) req |-> !wait_o)
		else $error("mpu: req while wait_o high");

endmodule

//--- common/blas_pkg.sv
// Shared sizes and encodings for the vector engine.
// Every RTL block imports this package with a wildcard import.

package blas_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////
	localparam int NUM_TPUS = 2;						// Thread units in the chain
	localparam int DATA_W = 16;
	localparam int MEM_DEPTH = 8;
	localparam int ADDR_W = $clog2(MEM_DEPTH);
	localparam logic [ADDR_W-1:0] Y_BASE = ADDR_W'(4);	// Vector y starts here

	// Router destination width, at least one bit
	localparam int DST_W = (NUM_TPUS > 1) ? $clog2(NUM_TPUS) : 1;

	// Write flight counter, covers the longest hop count
	localparam int FLY_W = $clog2(NUM_TPUS + 1);

	// Issue numbers wrap and index the commit buffer directly
	localparam int ISSUE_W = 2;
	localparam int AGG_DEPTH = 2**ISSUE_W;

	//////////////////////////////
	// Encodings
	//////////////////////////////
	typedef enum logic [1:0] {
		CMD_WRITE	= 2'd0,
		CMD_READ	= 2'd1,
		CMD_EXEC	= 2'd2
	} cmd_e;

	typedef enum logic [1:0] {
		OP_SCALE	= 2'd0,		// y = a*x
		OP_AXPY		= 2'd1,		// y = a*x + y
		OP_ADD		= 2'd2		// y = x + y
	} op_e;

	typedef enum logic [1:0] {
		ST_IDLE		= 2'd0,
		ST_RUN		= 2'd1,
		ST_TERM		= 2'd2
	} tpu_st_e;

endpackage
